// ==== files.f ====
+incdir+verif
common/backend_pkg.sv
exec/regfile.sv
exec/int_alu.sv
exec/exec_unit.sv
design/decode_unit.sv
design/issue_queue.sv
design/backend.sv
verif/backend_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --top-module backend_tb -f files.f -o backend_sim \
    && ./obj_dir/backend_sim > sim.log 2>&1
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/iss_model.svh ====
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

// rv64i opcodes used by the model and the program generator
localparam logic [6:0] OP_REG    = 7'b0110011;
localparam logic [6:0] OP_IMM    = 7'b0010011;
localparam logic [6:0] OP_LUI    = 7'b0110111;
localparam logic [6:0] OP_AUIPC  = 7'b0010111;
localparam logic [6:0] OP_JAL    = 7'b1101111;
localparam logic [6:0] OP_JALR   = 7'b1100111;
localparam logic [6:0] OP_BRANCH = 7'b1100011;
localparam logic [6:0] OP_LOAD   = 7'b0000011;

// architectural state of the model where x0 is never written
xlen_t model_regs [NUM_AREG];

task automatic model_reset();
    for (int r = 0; r < NUM_AREG; r++) begin
        model_regs[r] = '0;
    end
endtask

// executes one instruction and returns what the back end should retire
function automatic retire_t iss_step(input pc_t pc, input instr_t instr,
                                     output logic taken, output pc_t next_pc);
    retire_t    ret;
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      a;
    xlen_t      b;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    xlen_t      res;
    logic       writes;
    logic [5:0] sh;

    f3      = instr[14:12];
    f7      = instr[31:25];
    a       = model_regs[instr[19:15]];
    b       = model_regs[instr[24:20]];
    imm_i   = {{52{instr[31]}}, instr[31:20]};
    imm_b   = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u   = {{32{instr[31]}}, instr[31:12], 12'b0};
    imm_j   = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    res     = '0;
    writes  = 1'b0;
    taken   = 1'b0;
    next_pc = pc + 64'd4;
    case (instr[6:0])
        OP_REG: begin
            sh     = b[5:0];
            writes = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            case (f3)
                3'd0: res = f7[5] ? a - b : a + b;
                3'd1: res = a << sh;
                3'd2: res = {63'd0, $signed(a) < $signed(b)};
                3'd3: res = {63'd0, a < b};
                3'd4: res = a ^ b;
                3'd5: begin
                    if (f7[5]) begin
                        res = $signed(a) >>> sh;
                    end else begin
                        res = a >> sh;
                    end
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end
        OP_IMM: begin
            sh     = instr[25:20];
            writes = 1'b1;
            case (f3)
                3'd0: res = a + imm_i;
                3'd1: begin
                    writes = (instr[31:26] == 6'h00);
                    res    = a << sh;
                end
                3'd2: res = {63'd0, $signed(a) < $signed(imm_i)};
                3'd3: res = {63'd0, a < imm_i};
                3'd4: res = a ^ imm_i;
                3'd5: begin
                    writes = (instr[31:26] == 6'h00) || (instr[31:26] == 6'h10);
                    if (instr[30]) begin
                        res = $signed(a) >>> sh;
                    end else begin
                        res = a >> sh;
                    end
                end
                3'd6: res = a | imm_i;
                default: res = a & imm_i;
            endcase
        end
        OP_LUI: begin
            res    = imm_u;
            writes = 1'b1;
        end
        OP_AUIPC: begin
            res    = pc + imm_u;
            writes = 1'b1;
        end
        OP_JAL: begin
            res     = pc + 64'd4;
            writes  = 1'b1;
            taken   = 1'b1;
            next_pc = pc + imm_j;
        end
        OP_JALR: begin
            if (f3 == 3'd0) begin
                res     = pc + 64'd4;
                writes  = 1'b1;
                taken   = 1'b1;
                next_pc = (a + imm_i) & ~64'd1;
            end
        end
        OP_BRANCH: begin
            case (f3)
                3'd0: taken = (a == b);
                3'd1: taken = (a != b);
                3'd4: taken = $signed(a) < $signed(b);
                3'd5: taken = $signed(a) >= $signed(b);
                3'd6: taken = a < b;
                3'd7: taken = a >= b;
                default: taken = 1'b0;
            endcase
            if (taken) begin
                next_pc = pc + imm_b;
            end
        end
        default: writes = 1'b0;
    endcase
    ret.pc     = pc;
    ret.rd     = instr[11:7];
    ret.wen    = writes && (instr[11:7] != 5'd0);
    ret.result = res;
    if (ret.wen) begin
        model_regs[ret.rd] = res;
    end
    return ret;
endfunction

`endif

// ==== verif/backend_tb.sv ====
`timescale 1ns/100ps

module backend_tb;
    import backend_pkg::*;

    `include "iss_model.svh"

    localparam int QUEUE_DEPTH = 4;
    localparam int PROG_WORDS  = 64;
    localparam int NUM_INSTR   = 200;
    localparam int CLK_PERIOD  = 8;
    localparam int TIMEOUT_NS  = NUM_INSTR * 20 * CLK_PERIOD;

    logic    clock;
    logic    arst_n;
    logic    ibuffer_instr_valid;
    logic    ibuffer_ready;
    fetch_t  ibuffer_entry;
    logic    redirect_valid;
    pc_t     redirect_target;
    logic    retire_valid;
    retire_t retire;

    instr_t  prog_mem [PROG_WORDS];
    integer  seed;
    pc_t     drv_pc;
    pc_t     model_pc;
    logic    checking;
    logic    accepted_seen;
    logic    redirect_seen;
    pc_t     redirect_pc;
    int      retire_count;
    int      kept_count;
    retire_t exp_retire;
    logic    exp_taken;
    pc_t     exp_next;

    backend #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) dut (
        .clock              (clock),
        .arst_n             (arst_n),
        .ibuffer_instr_valid(ibuffer_instr_valid),
        .ibuffer_ready      (ibuffer_ready),
        .ibuffer_entry      (ibuffer_entry),
        .redirect_valid     (redirect_valid),
        .redirect_target    (redirect_target),
        .retire_valid       (retire_valid),
        .retire             (retire)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_value(name, 64'(got), 64'(exp));
        end
    endtask

    // rd and result only matter when the instruction writes
    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got.pc !== exp.pc) begin
            report_value("retire.pc", got.pc, exp.pc);
        end else if (got.wen !== exp.wen) begin
            report_value("retire.wen", 64'(got.wen), 64'(exp.wen));
        end else if (exp.wen && got.rd !== exp.rd) begin
            report_value("retire.rd", 64'(got.rd), 64'(exp.rd));
        end else if (exp.wen && got.result !== exp.result) begin
            report_value("retire.result", got.result, exp.result);
        end
    endtask

    task automatic check_redirect(input logic got_valid, input pc_t got_target,
                                  input logic exp_valid, input pc_t exp_target);
        if (got_valid !== exp_valid) begin
            report_value("redirect_valid", 64'(got_valid), 64'(exp_valid));
        end else if (exp_valid && got_target !== exp_target) begin
            report_value("redirect_target", got_target, exp_target);
        end
    endtask

    function automatic int pick(input int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    // random idle cycles in the first half only
    function automatic logic fetch_active();
        return (retire_count >= NUM_INSTR / 2) || (pick(4) != 0);
    endfunction

    function automatic instr_t r_type(input logic [6:0] f7, input areg_t rs2, input areg_t rs1,
                                      input logic [2:0] f3, input areg_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm, input areg_t rs1,
                                      input logic [2:0] f3, input areg_t rd,
                                      input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t b_type(input logic [12:0] off, input areg_t rs2, input areg_t rs1,
                                      input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic instr_t u_type(input logic [19:0] imm, input areg_t rd,
                                      input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic instr_t j_type(input logic [20:0] off, input areg_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // control flow stays inside the 64 words and the last word jumps back to 0
    task automatic build_program();
        int          kind;
        int          span;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        areg_t       rd;
        areg_t       rs1;
        areg_t       rs2;
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            kind = pick(16);
            rd   = areg_t'(pick(8));
            rs1  = areg_t'(pick(8));
            rs2  = areg_t'(pick(8));
            f3   = 3'(pick(8));
            span = (PROG_WORDS - 1 - i < 8) ? PROG_WORDS - 1 - i : 8;
            if (kind < 5) begin
                f7 = 7'h00;
                if ((f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1) begin
                    f7 = 7'h20;
                end
                prog_mem[i] = r_type(f7, rs2, rs1, f3, rd);
            end else if (kind < 9) begin
                imm = 12'(pick(4096));
                if (f3 == 3'd1) begin
                    imm = {6'd0, imm[5:0]};
                end else if (f3 == 3'd5) begin
                    imm = {1'b0, 1'(pick(2)), 4'd0, imm[5:0]};
                end
                prog_mem[i] = i_type(imm, rs1, f3, rd, OP_IMM);
            end else if (kind == 9) begin
                prog_mem[i] = u_type(20'(pick(1 << 20)), rd, OP_LUI);
            end else if (kind == 10) begin
                prog_mem[i] = u_type(20'(pick(1 << 20)), rd, OP_AUIPC);
            end else if (kind < 13) begin
                // branch funct3 values 0 1 4 5 6 7
                f3 = 3'(pick(6));
                if (f3 > 3'd1) begin
                    f3 = f3 + 3'd2;
                end
                prog_mem[i] = b_type(13'(4 * (1 + pick(span))), rs2, rs1, f3);
            end else if (kind == 13) begin
                prog_mem[i] = j_type(21'(4 * (1 + pick(span))), rd);
            end else if (kind == 14) begin
                // absolute target through x0 and sometimes odd to exercise bit 0 clearing
                imm = 12'(4 * (i + 1 + pick(span)) + pick(2));
                prog_mem[i] = i_type(imm, 5'd0, 3'd0, rd, OP_JALR);
            end else begin
                prog_mem[i] = {25'(pick(1 << 25)), OP_LOAD};
            end
        end
        prog_mem[PROG_WORDS-1] = j_type(21'(-(4 * (PROG_WORDS - 1))), 5'd0);
    endtask

    // compare each retire with the model and track the entries that must retire
    always @(posedge clock) begin
        if (checking) begin
            if (retire_valid) begin
                exp_retire = iss_step(model_pc, prog_mem[model_pc[7:2]], exp_taken, exp_next);
                check_retire(retire, exp_retire);
                check_redirect(redirect_valid, redirect_target, exp_taken, exp_next);
                model_pc     = exp_next;
                retire_count = retire_count + 1;
            end else begin
                check_redirect(redirect_valid, redirect_target, 1'b0, '0);
            end
            accepted_seen = ibuffer_instr_valid && ibuffer_ready;
            redirect_seen = redirect_valid;
            if (redirect_valid) begin
                // younger entries and one accepted now are flushed
                redirect_pc = redirect_target;
                kept_count  = retire_count;
            end else if (accepted_seen) begin
                kept_count = kept_count + 1;
            end
        end
    end

    initial begin
        seed                = 56;
        arst_n              = 1'b0;
        ibuffer_instr_valid = 1'b0;
        ibuffer_entry       = '0;
        checking            = 1'b0;
        accepted_seen       = 1'b0;
        redirect_seen       = 1'b0;
        redirect_pc         = '0;
        retire_count        = 0;
        kept_count          = 0;
        model_pc            = '0;
        drv_pc              = '0;
        model_reset();
        build_program();
        repeat (8) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        check_flag("retire_valid", retire_valid, 1'b0);
        check_flag("redirect_valid", redirect_valid, 1'b0);
        check_flag("ibuffer_ready", ibuffer_ready, 1'b1);
        checking            = 1'b1;
        ibuffer_instr_valid = fetch_active();
        ibuffer_entry.instr = prog_mem[drv_pc[7:2]];
        ibuffer_entry.pc    = drv_pc;
        while (retire_count < NUM_INSTR) begin
            @(negedge clock);
            if (redirect_seen) begin
                drv_pc              = redirect_pc;
                ibuffer_instr_valid = fetch_active();
            end else if (accepted_seen) begin
                drv_pc              = drv_pc + 64'd4;
                ibuffer_instr_valid = fetch_active();
            end else if (!ibuffer_instr_valid) begin
                ibuffer_instr_valid = fetch_active();
            end
            ibuffer_entry.instr = prog_mem[drv_pc[7:2]];
            ibuffer_entry.pc    = drv_pc;
        end
        // stop fetching and wait for every kept entry to retire
        @(negedge clock);
        ibuffer_instr_valid = 1'b0;
        while (retire_count < kept_count) begin
            @(negedge clock);
        end
        if (retire_count == kept_count) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run($sformatf("retire count %0d is above the %0d entries that should retire",
                                retire_count, kept_count));
        end
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run("timeout: the back end stopped retiring before the run ended");
    end

endmodule

// ==== design/backend.sv ====
`timescale 1ns/100ps

module backend #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clock,
    input  logic                 arst_n,
    // front end
    input  logic                 ibuffer_instr_valid,
    output logic                 ibuffer_ready,
    input  backend_pkg::fetch_t  ibuffer_entry,
    // redirect
    output logic                 redirect_valid,
    output backend_pkg::pc_t     redirect_target,
    // retire
    output logic                 retire_valid,
    output backend_pkg::retire_t retire
);
    import backend_pkg::*;

    logic enq_valid;
    logic enq_ready;
    uop_t enq_uop;
    logic deq_valid;
    logic deq_ready;
    uop_t deq_uop;

    decode_unit u_decode_unit (
        .clock    (clock),
        .arst_n   (arst_n),
        .flush    (redirect_valid),
        .in_valid (ibuffer_instr_valid),
        .in_ready (ibuffer_ready),
        .in_entry (ibuffer_entry),
        .enq_valid(enq_valid),
        .enq_ready(enq_ready),
        .enq_uop  (enq_uop)
    );

    issue_queue #(
        .DEPTH(QUEUE_DEPTH)
    ) u_issue_queue (
        .clock    (clock),
        .arst_n   (arst_n),
        .flush    (redirect_valid),
        .enq_valid(enq_valid),
        .enq_ready(enq_ready),
        .enq_uop  (enq_uop),
        .deq_valid(deq_valid),
        .deq_ready(deq_ready),
        .deq_uop  (deq_uop)
    );

    exec_unit u_exec_unit (
        .clock          (clock),
        .arst_n         (arst_n),
        .deq_valid      (deq_valid),
        .deq_ready      (deq_ready),
        .deq_uop        (deq_uop),
        .redirect_valid (redirect_valid),
        .redirect_target(redirect_target),
        .retire_valid   (retire_valid),
        .retire         (retire)
    );

endmodule

// ==== design/issue_queue.sv ====
`timescale 1ns/100ps

module issue_queue #(
    parameter int DEPTH = 4
) (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              enq_valid,
    output logic              enq_ready,
    input  backend_pkg::uop_t enq_uop,
    output logic              deq_valid,
    input  logic              deq_ready,
    output backend_pkg::uop_t deq_uop
);
    import backend_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    uop_t             entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign deq_valid = (count != '0);
    assign deq_uop   = entries[rd_ptr];
    assign pop       = deq_valid && deq_ready;
    // a slot frees up this cycle if the head is popped
    assign enq_ready = !full || pop;
    assign push      = enq_valid && enq_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push && !flush) begin
            entries[wr_ptr] <= enq_uop;
        end
    end

endmodule

// ==== design/decode_unit.sv ====
`timescale 1ns/100ps

module decode_unit (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                in_valid,
    output logic                in_ready,
    input  backend_pkg::fetch_t in_entry,
    output logic                enq_valid,
    input  logic                enq_ready,
    output backend_pkg::uop_t   enq_uop
);
    import backend_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    instr_t     instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    uop_t       dec_uop;
    logic       known;
    logic       has_rd;
    logic       uop_valid;

    // funct3 to alu op, alt picks sub / sra
    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign instr  = in_entry.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // sign-extended immediates
    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec_uop             = '0;
        dec_uop.pc          = in_entry.pc;
        dec_uop.rs1         = instr[19:15];
        dec_uop.rs2         = instr[24:20];
        dec_uop.rd          = instr[11:7];
        dec_uop.alu_op      = ALU_ADD;
        dec_uop.br_op       = BR_NONE;
        known               = 1'b0;
        has_rd              = 1'b1;
        case (opcode)
            OPC_OP: begin
                dec_uop.src1_is_reg = 1'b1;
                dec_uop.src2_is_reg = 1'b1;
                dec_uop.alu_op      = f3_to_alu(funct3, funct7[5]);
                known = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                dec_uop.src1_is_reg = 1'b1;
                dec_uop.imm         = imm_i;
                dec_uop.alu_op      = f3_to_alu(funct3, funct3 == 3'b101 && instr[30]);
                // rv64 shifts keep a 6-bit shamt, upper bits fixed
                case (funct3)
                    3'b001:  known = (instr[31:26] == 6'b000000);
                    3'b101:  known = (instr[31:26] == 6'b000000) ||
                                     (instr[31:26] == 6'b010000);
                    default: known = 1'b1;
                endcase
            end
            OPC_LUI: begin
                dec_uop.imm    = imm_u;
                dec_uop.alu_op = ALU_PASS;
                known          = 1'b1;
            end
            OPC_AUIPC: begin
                dec_uop.imm = imm_u;
                known       = 1'b1;
            end
            OPC_JAL: begin
                dec_uop.imm    = imm_j;
                dec_uop.alu_op = ALU_LINK;
                dec_uop.br_op  = BR_JAL;
                known          = 1'b1;
            end
            OPC_JALR: begin
                dec_uop.src1_is_reg = 1'b1;
                dec_uop.imm         = imm_i;
                dec_uop.alu_op      = ALU_LINK;
                dec_uop.br_op       = BR_JALR;
                known               = (funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                dec_uop.src1_is_reg = 1'b1;
                dec_uop.src2_is_reg = 1'b1;
                dec_uop.imm         = imm_b;
                has_rd              = 1'b0;
                known               = 1'b1;
                case (funct3)
                    3'b000:  dec_uop.br_op = BR_EQ;
                    3'b001:  dec_uop.br_op = BR_NE;
                    3'b100:  dec_uop.br_op = BR_LT;
                    3'b101:  dec_uop.br_op = BR_GE;
                    3'b110:  dec_uop.br_op = BR_LTU;
                    3'b111:  dec_uop.br_op = BR_GEU;
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase
        // unknown encodings become a no-op with no sources
        if (!known) begin
            dec_uop.src1_is_reg = 1'b0;
            dec_uop.src2_is_reg = 1'b0;
            dec_uop.alu_op      = ALU_ADD;
            dec_uop.br_op       = BR_NONE;
        end
        dec_uop.need_to_wb = known && has_rd && (dec_uop.rd != 5'd0);
    end

    // advance when empty or downstream takes the current uop
    assign in_ready  = !uop_valid || enq_ready;
    assign enq_valid = uop_valid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            uop_valid <= 1'b0;
        end else if (flush) begin
            uop_valid <= 1'b0;
        end else if (in_ready) begin
            uop_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_ready && in_valid) begin
            enq_uop <= dec_uop;
        end
    end

endmodule

// ==== exec/exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit (
    input  logic                 clock,
    input  logic                 arst_n,
    // from issue queue
    input  logic                 deq_valid,
    output logic                 deq_ready,
    input  backend_pkg::uop_t    deq_uop,
    // redirect
    output logic                 redirect_valid,
    output backend_pkg::pc_t     redirect_target,
    // retire
    output logic                 retire_valid,
    output backend_pkg::retire_t retire
);
    import backend_pkg::*;

    xlen_t               rdata1;
    xlen_t               rdata2;
    xlen_t               op1;
    xlen_t               op2;
    xlen_t               alu_result;
    logic                alu_taken;
    pc_t                 alu_target;
    logic [NUM_AREG-1:0] busy;
    logic                br_in_flight;
    logic                src1_busy;
    logic                src2_busy;
    logic                issue;
    logic                wb_valid;
    logic                wb_taken;
    pc_t                 wb_target;
    retire_t             wb_retire;

    regfile u_regfile (
        .clock (clock),
        .arst_n(arst_n),
        .rs1   (deq_uop.rs1),
        .rs2   (deq_uop.rs2),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .wen   (wb_valid && wb_retire.wen),
        .waddr (wb_retire.rd),
        .wdata (wb_retire.result)
    );

    // operand select, pc stands in for rs1 on auipc and jal
    assign op1 = deq_uop.src1_is_reg ? rdata1 : deq_uop.pc;
    assign op2 = deq_uop.src2_is_reg ? rdata2 : deq_uop.imm;

    int_alu u_int_alu (
        .op1   (op1),
        .op2   (op2),
        .pc    (deq_uop.pc),
        .imm   (deq_uop.imm),
        .alu_op(deq_uop.alu_op),
        .br_op (deq_uop.br_op),
        .result(alu_result),
        .taken (alu_taken),
        .target(alu_target)
    );

    // no bypass, wait for the producer to write the regfile
    assign src1_busy = deq_uop.src1_is_reg && busy[deq_uop.rs1];
    assign src2_busy = deq_uop.src2_is_reg && busy[deq_uop.rs2];
    assign issue     = deq_valid && !src1_busy && !src2_busy && !br_in_flight;
    assign deq_ready = issue;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy         <= '0;
            br_in_flight <= 1'b0;
            wb_valid     <= 1'b0;
        end else begin
            wb_valid <= issue;
            if (wb_valid && wb_retire.wen) begin
                busy[wb_retire.rd] <= 1'b0;
            end
            // a new writer of the same rd keeps it busy
            if (issue && deq_uop.need_to_wb) begin
                busy[deq_uop.rd] <= 1'b1;
            end
            if (issue && deq_uop.br_op != BR_NONE) begin
                br_in_flight <= 1'b1;
            end else if (wb_valid) begin
                br_in_flight <= 1'b0;
            end
        end
    end

    // writeback stage
    always_ff @(posedge clock) begin
        if (issue) begin
            wb_retire.pc     <= deq_uop.pc;
            wb_retire.rd     <= deq_uop.rd;
            wb_retire.wen    <= deq_uop.need_to_wb;
            wb_retire.result <= alu_result;
            wb_taken         <= alu_taken;
            wb_target        <= alu_target;
        end
    end

    assign retire_valid    = wb_valid;
    assign retire          = wb_retire;
    assign redirect_valid  = wb_valid && wb_taken;
    assign redirect_target = wb_target;

endmodule

// ==== exec/int_alu.sv ====
`timescale 1ns/100ps

module int_alu (
    input  backend_pkg::xlen_t   op1,
    input  backend_pkg::xlen_t   op2,
    input  backend_pkg::pc_t     pc,
    input  backend_pkg::xlen_t   imm,
    input  backend_pkg::alu_op_e alu_op,
    input  backend_pkg::br_op_e  br_op,
    output backend_pkg::xlen_t   result,
    output logic                 taken,
    output backend_pkg::pc_t     target
);
    import backend_pkg::*;

    logic [5:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;
    xlen_t      jalr_sum;

    assign shamt    = op2[5:0];
    assign lt_s     = $signed(op1) < $signed(op2);
    assign lt_u     = op1 < op2;
    assign eq       = (op1 == op2);
    assign jalr_sum = op1 + imm;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = op1 + op2;
            ALU_SUB:  result = op1 - op2;
            ALU_AND:  result = op1 & op2;
            ALU_OR:   result = op1 | op2;
            ALU_XOR:  result = op1 ^ op2;
            ALU_SLL:  result = op1 << shamt;
            ALU_SRL:  result = op1 >> shamt;
            ALU_SRA:  result = $signed(op1) >>> shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_PASS: result = imm;
            // return address for jal / jalr
            ALU_LINK: result = pc + 64'd4;
            default:  result = '0;
        endcase
    end

    always_comb begin
        case (br_op)
            BR_EQ:   taken = eq;
            BR_NE:   taken = !eq;
            BR_LT:   taken = lt_s;
            BR_GE:   taken = !lt_s;
            BR_LTU:  taken = lt_u;
            BR_GEU:  taken = !lt_u;
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr clears bit 0 of rs1 + imm
    assign target = (br_op == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;

endmodule

// ==== exec/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic               clock,
    input  logic               arst_n,
    input  backend_pkg::areg_t rs1,
    input  backend_pkg::areg_t rs2,
    output backend_pkg::xlen_t rdata1,
    output backend_pkg::xlen_t rdata2,
    input  logic               wen,
    input  backend_pkg::areg_t waddr,
    input  backend_pkg::xlen_t wdata
);
    import backend_pkg::*;

    // x1 .. x31, x0 has no storage
    xlen_t regs [1:NUM_AREG-1];

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NUM_AREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== common/backend_pkg.sv ====
package backend_pkg;

    // datapath widths
    parameter int XLEN     = 64;
    parameter int NUM_AREG = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [63:0]     pc_t;
    typedef logic [4:0]      areg_t;
    typedef logic [31:0]     instr_t;

    // alu operation select
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_PASS = 4'd10,
        ALU_LINK = 4'd11
    } alu_op_e;

    // branch and jump kinds
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_EQ   = 4'd1,
        BR_NE   = 4'd2,
        BR_LT   = 4'd3,
        BR_GE   = 4'd4,
        BR_LTU  = 4'd5,
        BR_GEU  = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } br_op_e;

    // front end entry
    typedef struct packed {
        instr_t instr;
        pc_t    pc;
    } fetch_t;

    // decoded micro-op
    typedef struct packed {
        pc_t     pc;
        areg_t   rs1;
        areg_t   rs2;
        areg_t   rd;
        xlen_t   imm;
        logic    src1_is_reg;
        logic    src2_is_reg;
        logic    need_to_wb;
        alu_op_e alu_op;
        br_op_e  br_op;
    } uop_t;

    // one finished instruction
    typedef struct packed {
        pc_t   pc;
        areg_t rd;
        logic  wen;
        xlen_t result;
    } retire_t;

endpackage
